// ==== design/erx_pkg.sv ====
// link receiver shared definitions
// sizes, frame codes and the sampled transaction layout
package erx_pkg;

   //############################
   // sizes
   //############################

   // mesh packet width
   localparam int PW = 104;
   // body shift register, 12 bytes
   localparam int BODY_W = 96;
   // body cycles per packet, also the counter limit
   localparam int BODY_WORDS = 6;
   // body counter width
   localparam int CNT_W = 3;

   //############################
   // frame codes
   //############################

   localparam logic [1:0] FRAME_IDLE = 2'b00;
   localparam logic [1:0] FRAME_START = 2'b01;
   localparam logic [1:0] FRAME_BODY = 2'b11;
   // 2'b10 is treated as idle as well

   //############################
   // sampled transaction
   //############################

   // field view in wire order, header byte on top
   typedef struct packed {
      logic [3:0]  ctrlmode;
      logic [31:0] dstaddr;
      logic [1:0]  datamode;
      logic        write;
      logic        access;
      logic [31:0] data;
      logic [31:0] srcaddr;
   } erx_sample_fields_t;

   // raw byte view for the shifter, field view for the former
   typedef union packed {
      logic [PW-1:0]      raw;
      erx_sample_fields_t fields;
   } erx_sample_u;

endpackage

// ==== design/erx_byte_shifter.sv ====
// link receiver byte shifter
// pipes the link word and assembles the header byte and 96-bit body
`timescale 1ns/100ps

module erx_byte_shifter (
   input  logic                rx_lclk,
   input  logic                arst_n,
   input  logic [1:0]          rx_frame,
   input  logic [15:0]         rx_word,
   output erx_pkg::erx_sample_u sample
);

   import erx_pkg::*;

   // pipe stage copies
   logic [1:0]  frame_q;
   logic [15:0] word_q;

   //############################
   // input pipe stage
   //############################

   // frame is control, cleared to idle
   always_ff @(posedge rx_lclk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         frame_q <= FRAME_IDLE;
      end
      else
      begin
         frame_q <= rx_frame;
      end
   end

   // word is payload only
   always_ff @(posedge rx_lclk)
   begin
      word_q <= rx_word;
   end

   //############################
   // byte assembly
   //############################

   // header byte sits above the body in the raw view
   always_ff @(posedge rx_lclk)
   begin
      case (frame_q)
         FRAME_START:
         begin
            // header rides in the low lane, body untouched
            sample.raw[PW-1:BODY_W] <= word_q[7:0];
         end
         FRAME_BODY:
         begin
            // upper lane is the older byte, so it lands higher
            sample.raw[BODY_W-1:0] <= {sample.raw[BODY_W-17:0], word_q};
         end
         default:
         begin
            // idle and 10 just hold
            sample.raw <= sample.raw;
         end
      endcase
   end

endmodule

// ==== design/erx_frame_tracker.sv ====
// link receiver frame tracker
// counts body words, pulses packet completion and tracks burst state
`timescale 1ns/100ps

module erx_frame_tracker (
   input  logic       rx_lclk,
   input  logic       arst_n,
   input  logic [1:0] rx_frame,
   output logic       packet_done,
   output logic       burst_detect
);

   import erx_pkg::*;

   // own pipe stage, in step with the shifter
   logic [1:0]       frame_q;
   // body words seen in the current packet
   logic [CNT_W-1:0] body_cnt;

   //############################
   // frame pipe stage
   //############################

   always_ff @(posedge rx_lclk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         frame_q <= FRAME_IDLE;
      end
      else
      begin
         frame_q <= rx_frame;
      end
   end

   //############################
   // body counter
   //############################

   // wraps on the sixth body word so a burst keeps counting
   always_ff @(posedge rx_lclk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         body_cnt    <= '0;
         packet_done <= 1'b0;
      end
      else if (frame_q == FRAME_BODY)
      begin
         if (body_cnt == CNT_W'(BODY_WORDS - 1))
         begin
            body_cnt    <= '0;
            packet_done <= 1'b1;
         end
         else
         begin
            body_cnt    <= body_cnt + 1'b1;
            packet_done <= 1'b0;
         end
      end
      else
      begin
         // start or idle drops any partial packet
         body_cnt    <= '0;
         packet_done <= 1'b0;
      end
   end

   //############################
   // burst state
   //############################

   // set one edge after completion, so the former still sees the
   // old value for the packet that just finished
   always_ff @(posedge rx_lclk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         burst_detect <= 1'b0;
      end
      else if (frame_q != FRAME_BODY)
      begin
         burst_detect <= 1'b0;
      end
      else if (packet_done)
      begin
         // frame still in body, next packet is a burst
         burst_detect <= 1'b1;
      end
   end

endmodule

// ==== design/erx_packet_former.sv ====
// link receiver packet former
// remaps the sampled fields into the mesh packet layout on completion
`timescale 1ns/100ps

module erx_packet_former (
   input  logic                 rx_lclk,
   input  logic                 arst_n,
   input  erx_pkg::erx_sample_u sample,
   input  logic                 packet_done,
   input  logic                 burst_detect,
   output logic                 rx_access,
   output logic                 rx_burst,
   output logic [erx_pkg::PW-1:0] rx_packet
);

   //############################
   // access strobe
   //############################

   // one pulse per completed packet, no back-pressure
   always_ff @(posedge rx_lclk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         rx_access <= 1'b0;
      end
      else
      begin
         rx_access <= packet_done;
      end
   end

   //############################
   // packet capture
   //############################

   // packet and burst flag hold until the next capture
   always_ff @(posedge rx_lclk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         rx_burst  <= 1'b0;
         rx_packet <= '0;
      end
      else if (packet_done)
      begin
         rx_burst <= burst_detect;
         // mesh order, srcaddr on top down to access at bit 0
         rx_packet <= {sample.fields.srcaddr,
                       sample.fields.data,
                       sample.fields.dstaddr,
                       sample.fields.ctrlmode,
                       sample.fields.datamode,
                       sample.fields.write,
                       sample.fields.access};
      end
   end

endmodule

// ==== design/erx_io.sv ====
// link receiver core top
// joins the byte shifter, frame tracker and packet former
`timescale 1ns/100ps

module erx_io (
   input  logic                   rx_lclk,
   input  logic                   arst_n,
   input  logic [1:0]             rx_frame,
   input  logic [15:0]            rx_word,
   output logic                   rx_access,
   output logic                   rx_burst,
   output logic [erx_pkg::PW-1:0] rx_packet
);

   import erx_pkg::*;

   // assembled bytes, shifter to former
   erx_sample_u sample;
   // completion and burst, tracker to former
   logic        packet_done;
   logic        burst_detect;

   //############################
   // datapath and control
   //############################

   // both take the raw frame and pipe it themselves
   erx_byte_shifter erx_byte_shifter_inst (
      .rx_lclk  (rx_lclk),
      .arst_n   (arst_n),
      .rx_frame (rx_frame),
      .rx_word  (rx_word),
      .sample   (sample)
   );

   erx_frame_tracker erx_frame_tracker_inst (
      .rx_lclk      (rx_lclk),
      .arst_n       (arst_n),
      .rx_frame     (rx_frame),
      .packet_done  (packet_done),
      .burst_detect (burst_detect)
   );

   // output stage
   erx_packet_former erx_packet_former_inst (
      .rx_lclk      (rx_lclk),
      .arst_n       (arst_n),
      .sample       (sample),
      .packet_done  (packet_done),
      .burst_detect (burst_detect),
      .rx_access    (rx_access),
      .rx_burst     (rx_burst),
      .rx_packet    (rx_packet)
   );

endmodule

// ==== test/erx_io_assertions.sv ====
// link receiver protocol assertions
// strobe width, strobe spacing, known packet data, quiet reset
`timescale 1ns/100ps

module erx_io_assertions (
   input logic                   rx_lclk,
   input logic                   arst_n,
   input logic                   rx_access,
   input logic                   rx_burst,
   input logic [erx_pkg::PW-1:0] rx_packet
);

   // count of failed assertions
   int fail_cnt = 0;

   // strobe is a single cycle
   a_access_one_cycle: assert property (@(posedge rx_lclk) disable iff (!arst_n)
      rx_access |-> !$past(rx_access))
      else
      begin
         fail_cnt++;
         $error("rx_access held for two cycles");
      end

   // six body words per packet, so never closer than six cycles
   a_access_spacing: assert property (@(posedge rx_lclk) disable iff (!arst_n)
      rx_access |-> !($past(rx_access, 2) || $past(rx_access, 3) ||
                      $past(rx_access, 4) || $past(rx_access, 5)))
      else
      begin
         fail_cnt++;
         $error("rx_access pulses closer than six cycles");
      end

   a_packet_known: assert property (@(posedge rx_lclk) disable iff (!arst_n)
      rx_access |-> !$isunknown(rx_packet))
      else
      begin
         fail_cnt++;
         $error("rx_packet has unknown bits during rx_access");
      end

   // sampled on the falling edge away from reset release
   a_reset_quiet: assert property (@(negedge rx_lclk)
      !arst_n |-> (!rx_access && !rx_burst))
      else
      begin
         fail_cnt++;
         $error("rx_access or rx_burst high in reset");
      end

endmodule

// ==== test/erx_io_tb.sv ====
// link receiver testbench
// random single, burst, aborted and idle-10 packets against a reference mapping
`timescale 1ns/100ps

module erx_io_tb;

   import erx_pkg::*;

   // header byte first, then body bytes in arrival order
   typedef logic [0:12][7:0] txn_bytes_t;

   localparam int RESET_CYCLES = 4;
   localparam int MAX_GAP = 4;
   localparam int DRAIN_CYC = 12;
   // drive edge of the last body word to the access strobe
   localparam int ACCESS_EDGES = 3;
   localparam int PKT_CYC = 1 + BODY_WORDS;
   // worst case per test, in clock cycles
   localparam int TOTAL_CYC = (RESET_CYCLES + 4)
                            + (20 * (PKT_CYC + MAX_GAP) + DRAIN_CYC)
                            + (1 + 3 * BODY_WORDS + MAX_GAP + DRAIN_CYC)
                            + (BODY_WORDS * 2 * (PKT_CYC + MAX_GAP) + DRAIN_CYC)
                            + (4 * (PKT_CYC + 2 * MAX_GAP) + DRAIN_CYC);
   localparam int WATCHDOG_CYC = 2 * TOTAL_CYC + 100;

   logic          rx_lclk;
   logic          arst_n;
   logic [1:0]    rx_frame;
   logic [15:0]   rx_word;
   logic          rx_access;
   logic          rx_burst;
   logic [PW-1:0] rx_packet;

   logic [31:0]   rng_state = 32'h3c7bfe57;
   // rising edges seen so far
   int            edge_cnt = 0;
   int            error_cnt = 0;
   int            check_cnt = 0;
   int            test_cnt = 0;
   int            test_base = 0;
   // bound assertion failures already folded into error_cnt
   int            assert_seen = 0;

   // expected packets in arrival order
   logic [PW-1:0] exp_packet_q[$];
   logic          exp_burst_q[$];
   int            exp_edge_q[$];

   erx_io erx_io_inst (
      .rx_lclk   (rx_lclk),
      .arst_n    (arst_n),
      .rx_frame  (rx_frame),
      .rx_word   (rx_word),
      .rx_access (rx_access),
      .rx_burst  (rx_burst),
      .rx_packet (rx_packet)
   );

   bind erx_io erx_io_assertions erx_io_assertions_inst (
      .rx_lclk   (rx_lclk),
      .arst_n    (arst_n),
      .rx_access (rx_access),
      .rx_burst  (rx_burst),
      .rx_packet (rx_packet)
   );

   //############################
   // clock and helpers
   //############################

   initial
   begin
      rx_lclk = 1'b0;
      forever
         #2 rx_lclk = ~rx_lclk;
   end

   always @(posedge rx_lclk)
      edge_cnt <= edge_cnt + 1;

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      return y ^ (y << 5);
   endfunction

   function automatic logic [31:0] next_rand();
      rng_state = xorshift32(rng_state);
      return rng_state;
   endfunction

   // header above the body, then wire fields to mesh order
   function automatic logic [PW-1:0] ref_packet(input txn_bytes_t b);
      logic [PW-1:0] raw;
      raw = {b[0], b[1:12]};
      // srcaddr, data, dstaddr, ctrlmode, datamode, write, access
      return {raw[31:0], raw[63:32], raw[99:68], raw[103:100],
              raw[67:66], raw[65], raw[64]};
   endfunction

   task automatic check_value(input string name, input logic [PW-1:0] got,
                              input logic [PW-1:0] exp);
      check_cnt++;
      if (got !== exp)
      begin
         error_cnt++;
         $display("[FAIL] %s got %h expected %h", name, got, exp);
      end
   endtask

   task automatic check_outputs_clear();
      check_value("rx_access", PW'(rx_access), '0);
      check_value("rx_burst", PW'(rx_burst), '0);
      check_value("rx_packet", rx_packet, '0);
   endtask

   //############################
   // stimulus
   //############################

   task automatic drive(input logic [1:0] frame, input logic [15:0] word);
      @(posedge rx_lclk);
      rx_frame <= frame;
      rx_word  <= word;
   endtask

   // 1 to MAX_GAP cycles of the given idle code
   // junk on the word
   task automatic idle_gap(input logic [1:0] code);
      int n;
      n = int'(next_rand() % 32'(MAX_GAP)) + 1;
      repeat (n)
         drive(code, 16'(next_rand()));
   endtask

   task automatic random_bytes(output txn_bytes_t b);
      int i;
      for (i = 0; i < 13; i++)
         b[i] = 8'(next_rand());
   endtask

   // upper lane of a start cycle carries junk
   task automatic send_start(input txn_bytes_t b);
      drive(FRAME_START, {8'(next_rand()), b[0]});
   endtask

   // upper lane is the older byte
   // short counts leave nothing expected
   task automatic send_body(input txn_bytes_t b, input int n_words, input logic burst);
      int i;
      for (i = 0; i < n_words; i++)
         drive(FRAME_BODY, {b[1 + 2 * i], b[2 + 2 * i]});
      if (n_words == BODY_WORDS)
      begin
         exp_packet_q.push_back(ref_packet(b));
         exp_burst_q.push_back(burst);
         exp_edge_q.push_back(edge_cnt + 1 + ACCESS_EDGES);
      end
   endtask

   // queue only changes on falling edges, so poll on rising ones
   task automatic end_test(input string name);
      int n;
      n = 0;
      while (exp_packet_q.size() != 0 && n < DRAIN_CYC)
      begin
         @(posedge rx_lclk);
         n++;
      end
      if (exp_packet_q.size() != 0)
      begin
         error_cnt += exp_packet_q.size();
         $display("missing access pulse, %0d packets never arrived", exp_packet_q.size());
         exp_packet_q.delete();
         exp_burst_q.delete();
         exp_edge_q.delete();
      end
      error_cnt += erx_io_inst.erx_io_assertions_inst.fail_cnt - assert_seen;
      assert_seen = erx_io_inst.erx_io_assertions_inst.fail_cnt;
      test_cnt++;
      $display("test %0d %s: %0d errors", test_cnt, name, error_cnt - test_base);
      test_base = error_cnt;
   endtask

   //############################
   // compare
   //############################

   always @(negedge rx_lclk)
   begin
      if (!arst_n)
         check_outputs_clear();
      else if (rx_access && exp_packet_q.size() == 0)
      begin
         error_cnt++;
         $display("access pulse at edge %0d with no packet outstanding", edge_cnt);
      end
      else if (rx_access)
      begin
         check_value("rx_packet", rx_packet, exp_packet_q.pop_front());
         check_value("rx_burst", PW'(rx_burst), PW'(exp_burst_q.pop_front()));
         check_value("rx_access edge", PW'(edge_cnt), PW'(exp_edge_q.pop_front()));
      end
   end

   initial
   begin
      repeat (WATCHDOG_CYC)
         @(posedge rx_lclk);
      $display("timeout, run did not end within %0d cycles", WATCHDOG_CYC);
      $display("Regression failed");
      $finish;
   end

   //############################
   // tests
   //############################

   initial
   begin
      txn_bytes_t b;
      logic [7:0] hdr;
      int         i;
      arst_n   = 1'b0;
      rx_frame = FRAME_IDLE;
      rx_word  = '0;
      repeat (RESET_CYCLES)
         @(posedge rx_lclk);
      arst_n <= 1'b1;

      // quiet right after release
      repeat (4)
      begin
         @(negedge rx_lclk);
         check_outputs_clear();
      end
      end_test("reset state");

      for (i = 0; i < 20; i++)
      begin
         random_bytes(b);
         send_start(b);
         send_body(b, BODY_WORDS, 1'b0);
         idle_gap(FRAME_IDLE);
      end
      end_test("single packets");

      // one start, three packets, header reused
      random_bytes(b);
      hdr = b[0];
      send_start(b);
      for (i = 0; i < 3; i++)
      begin
         random_bytes(b);
         b[0] = hdr;
         send_body(b, BODY_WORDS, i != 0);
      end
      idle_gap(FRAME_IDLE);
      end_test("burst");

      // 0 to 5 body words, then a full packet
      for (i = 0; i < BODY_WORDS; i++)
      begin
         random_bytes(b);
         send_start(b);
         send_body(b, i, 1'b0);
         idle_gap(FRAME_IDLE);
         random_bytes(b);
         send_start(b);
         send_body(b, BODY_WORDS, 1'b0);
         idle_gap(FRAME_IDLE);
      end
      end_test("aborted frame");

      for (i = 0; i < 4; i++)
      begin
         idle_gap(2'b10);
         random_bytes(b);
         send_start(b);
         send_body(b, BODY_WORDS, 1'b0);
         idle_gap(2'b10);
      end
      end_test("idle code 10");

      $display("tests %0d, checks %0d, errors %0d", test_cnt, check_cnt, error_cnt);
      if (error_cnt == 0)
         $display("Regression passed");
      else
         $display("Regression failed");
      $finish;
   end

endmodule

// ==== compile.f ====
design/erx_pkg.sv
design/erx_byte_shifter.sv
design/erx_frame_tracker.sv
design/erx_packet_former.sv
design/erx_io.sv
test/erx_io_assertions.sv
test/erx_io_tb.sv

// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := erx_io_tb
FILELIST := compile.f
OBJ_DIR  := obj_dir
LOG      := sim.log

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "^Regression passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
